// File: design/gfx_mode_pkg.sv
package gfx_mode_pkg;

    // Pixel coordinate and video memory byte address
    typedef logic [15:0] coord_t;
    typedef logic [16:0] vaddr_t;

    // Codes taken from mode_control[2:0]
    typedef enum logic [2:0] {
        mode_640x480x2  = 3'd1,     // 1 bpp, two pages
        mode_640x480x4  = 3'd2,     // 2 bpp, one page
        mode_320x240x16 = 3'd3,     // 4 bpp, two pages
        mode_320x240x64 = 3'd4      // 8 bpp, one page
    } gfx_mode_e;

    // Geometry of the selected mode
    typedef struct packed {
        coord_t      width;
        coord_t      height;
        logic [3:0]  bits_per_pixel;
        logic        has_pages;
        vaddr_t      page_size;     // Bytes in one page
    } mode_geom_t;

endpackage

// File: design/gfx_cmd_pkg.sv
package gfx_cmd_pkg;

    // Instruction opcodes
    typedef enum logic [7:0] {
        op_write_pixel     = 8'h10,
        op_pixel_pos       = 8'h11,
        op_write_pixel_pos = 8'h12,
        op_clear_screen    = 8'h13,
        op_get_pixel_at    = 8'h14
    } gfx_opcode_e;

    // Controller states
    typedef enum logic [3:0] {
        st_idle,
        st_write_pixel,
        st_pixel_pos,
        st_write_pixel_pos,
        st_clear,
        st_get_addr,
        st_get_wait,
        st_get_read,
        st_rmw_read,
        st_rmw_wait,
        st_rmw_write
    } gfx_state_e;

endpackage

// File: design/video_ram.sv
`timescale 1ns/100ps

module video_ram #(
    parameter int addr_width = 17
) (
    input  logic                  video_clk,
    input  logic                  we,
    input  logic [addr_width-1:0] addr,
    input  logic [7:0]            wdata,
    output logic [7:0]            rdata
);
    logic [7:0] mem [0:(2**addr_width)-1];

    // Single port, read data one cycle after the address
    always_ff @(posedge video_clk) begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];
    end

endmodule

// File: design/gfx_pixel_merge.sv
`timescale 1ns/100ps

module gfx_pixel_merge (
    input  logic                     video_clk,
    input  logic                     reset_n,
    input  logic                     rmw_capture,
    input  logic                     extract_capture,
    input  logic [7:0]               ram_rdata,
    input  logic [2:0]               bit_pos,
    input  gfx_mode_pkg::mode_geom_t geom,
    input  logic [7:0]               pixel_value,
    output logic [7:0]               merged_byte,
    output logic [7:0]               result_pixel
);
    logic [8:0] wide_mask;
    logic [7:0] field_mask;

    // One field of bits_per_pixel ones, 8 bpp gives the whole byte
    assign wide_mask  = (9'd1 << geom.bits_per_pixel) - 9'd1;
    assign field_mask = wide_mask[7:0];

    // Insert the new pixel into the byte just read
    always_ff @(posedge video_clk) begin
        if (rmw_capture)
            merged_byte <= (ram_rdata & ~(field_mask << bit_pos))
                         | ((pixel_value & field_mask) << bit_pos);
    end

    // Pixel returned by GET_PIXEL_AT
    always_ff @(posedge video_clk or negedge reset_n) begin
        if (!reset_n)
            result_pixel <= 8'h00;
        else if (extract_capture)
            result_pixel <= (ram_rdata >> bit_pos) & field_mask;
    end

endmodule

// File: design/gfx_pixel_addr.sv
`timescale 1ns/100ps

module gfx_pixel_addr (
    input  logic [7:0]               mode_control,
    input  gfx_mode_pkg::coord_t     x,
    input  gfx_mode_pkg::coord_t     y,
    output gfx_mode_pkg::mode_geom_t geom,
    output gfx_mode_pkg::vaddr_t     pixel_addr,
    output logic [2:0]               bit_pos,
    output logic                     in_bounds
);
    import gfx_mode_pkg::*;

    logic [31:0] linear;
    logic [31:0] byte_off;
    vaddr_t      page_off;

    // Mode decode: width, height, bpp, pages, page size
    always_comb begin
        case (gfx_mode_e'(mode_control[2:0]))
            mode_640x480x2:  geom = '{16'd640, 16'd480, 4'd1, 1'b1, 17'd38400};
            mode_640x480x4:  geom = '{16'd640, 16'd480, 4'd2, 1'b0, 17'd76800};
            mode_320x240x16: geom = '{16'd320, 16'd240, 4'd4, 1'b1, 17'd38400};
            mode_320x240x64: geom = '{16'd320, 16'd240, 4'd8, 1'b0, 17'd76800};
            default:         geom = '{16'd640, 16'd480, 4'd1, 1'b0, 17'd38400};
        endcase
    end

    assign in_bounds = (x < geom.width) && (y < geom.height);

    always_comb begin
        linear = 32'(y) * 32'(geom.width) + 32'(x);
        case (geom.bits_per_pixel)
            4'd1: begin
                byte_off = linear >> 3;
                bit_pos  = 3'd7 - x[2:0];           // Leftmost pixel in the MSB
            end
            4'd2: begin
                byte_off = linear >> 2;
                bit_pos  = 3'd6 - {x[1:0], 1'b0};
            end
            4'd4: begin
                byte_off = linear >> 1;
                bit_pos  = x[0] ? 3'd0 : 3'd4;      // Even x in the high nibble
            end
            default: begin
                byte_off = linear;
                bit_pos  = 3'd0;
            end
        endcase
        page_off   = (geom.has_pages && mode_control[4]) ? geom.page_size : '0;
        pixel_addr = page_off + byte_off[16:0];
    end

endmodule

// File: design/gfx_clear_counter.sv
`timescale 1ns/100ps

module gfx_clear_counter (
    input  logic                     video_clk,
    input  logic                     reset_n,
    input  logic                     clear_start,
    input  logic                     clear_step,
    input  gfx_mode_pkg::mode_geom_t geom,
    input  logic                     working_page,
    output gfx_mode_pkg::vaddr_t     clear_addr,
    output logic                     clear_last
);
    import gfx_mode_pkg::*;

    vaddr_t count;

    always_ff @(posedge video_clk or negedge reset_n) begin
        if (!reset_n)
            count <= '0;
        else if (clear_start)
            count <= '0;
        else if (clear_step)
            count <= count + 17'd1;
    end

    assign clear_last = (count == geom.page_size - 17'd1);
    assign clear_addr = (geom.has_pages && working_page) ? count + geom.page_size
                                                         : count;    // Page 1 sits above page 0

endmodule

// File: design/gfx_cursor.sv
`timescale 1ns/100ps

module gfx_cursor (
    input  logic                     video_clk,
    input  logic                     reset_n,
    input  logic                     cursor_load,
    input  gfx_mode_pkg::coord_t     load_x,
    input  gfx_mode_pkg::coord_t     load_y,
    input  logic                     cursor_advance,
    input  logic                     cursor_home,
    input  gfx_mode_pkg::mode_geom_t geom,
    output gfx_mode_pkg::coord_t     cursor_x,
    output gfx_mode_pkg::coord_t     cursor_y
);
    import gfx_mode_pkg::*;

    coord_t base_x, base_y;

    // Position that an advance starts from
    assign base_x = cursor_load ? load_x : cursor_x;
    assign base_y = cursor_load ? load_y : cursor_y;

    always_ff @(posedge video_clk or negedge reset_n) begin
        if (!reset_n) begin
            cursor_x <= '0;
            cursor_y <= '0;
        end else if (cursor_home) begin
            cursor_x <= '0;
            cursor_y <= '0;
        end else if (cursor_advance) begin
            if (base_x == geom.width - 16'd1) begin   // End of line
                cursor_x <= '0;
                cursor_y <= (base_y == geom.height - 16'd1) ? '0 : base_y + 16'd1;
            end else begin
                cursor_x <= base_x + 16'd1;
                cursor_y <= base_y;
            end
        end else if (cursor_load) begin
            cursor_x <= load_x;
            cursor_y <= load_y;
        end
    end

endmodule

// File: design/gfx_cmd_fsm.sv
`timescale 1ns/100ps

module gfx_cmd_fsm (
    input  logic                    video_clk,
    input  logic                    reset_n,
    input  logic [7:0]              instruction,
    input  logic [7:0]              arg0,
    input  logic [7:0]              arg1,
    input  logic [7:0]              arg2,
    input  logic [7:0]              arg3,
    input  logic [7:0]              arg4,
    input  logic                    instruction_start,
    input  logic                    in_bounds,
    input  logic                    clear_last,
    input  gfx_mode_pkg::mode_geom_t geom,
    output logic                    instruction_busy,
    output logic                    instruction_finished,
    output logic                    instruction_error,
    output gfx_mode_pkg::coord_t    arg_x,
    output gfx_mode_pkg::coord_t    arg_y,
    output logic [7:0]              arg_value,
    output logic [7:0]              clear_fill,
    output logic                    cursor_load,
    output logic                    cursor_advance,
    output logic                    cursor_home,
    output logic                    clear_start,
    output logic                    clear_step,
    output logic                    addr_sel,
    output logic                    rmw_capture,
    output logic                    extract_capture,
    output logic                    ram_we,
    output logic                    ram_addr_sel,
    output logic [1:0]              data_sel
);
    import gfx_cmd_pkg::*;

    gfx_state_e state;
    logic [1:0] start_sync;
    logic       start_prev;
    logic       start_edge, accept, direct, pos_cmd;

    assign start_edge = start_sync[1] & ~start_prev;
    assign accept     = start_edge && (state == st_idle) && !instruction_busy;
    assign direct     = (geom.bits_per_pixel == 4'd8);  // No read-modify-write needed
    assign addr_sel   = pos_cmd;

    // ========================================================================
    // Start synchronizer, state register and status outputs
    // ========================================================================
    always_ff @(posedge video_clk or negedge reset_n) begin
        if (!reset_n) begin
            start_sync           <= 2'b00;
            start_prev           <= 1'b0;
            state                <= st_idle;
            pos_cmd              <= 1'b0;
            instruction_busy     <= 1'b0;
            instruction_finished <= 1'b0;
            instruction_error    <= 1'b0;
        end else begin
            start_sync           <= {start_sync[0], instruction_start};
            start_prev           <= start_sync[1];
            instruction_finished <= 1'b0;
            instruction_error    <= 1'b0;

            case (state)
                st_idle: begin
                    instruction_busy <= 1'b0;
                    if (accept) begin
                        instruction_busy <= 1'b1;
                        pos_cmd <= (instruction == op_write_pixel_pos) ||
                                   (instruction == op_get_pixel_at);
                        case (instruction)
                            op_write_pixel:     state <= st_write_pixel;
                            op_pixel_pos:       state <= st_pixel_pos;
                            op_write_pixel_pos: state <= st_write_pixel_pos;
                            op_clear_screen:    state <= st_clear;
                            op_get_pixel_at:    state <= st_get_addr;
                            default: begin                  // Unknown opcode
                                instruction_busy  <= 1'b0;
                                instruction_error <= 1'b1;
                            end
                        endcase
                    end
                end
                st_pixel_pos: begin
                    instruction_finished <= 1'b1;
                    state                <= st_idle;
                end
                st_write_pixel, st_write_pixel_pos: begin
                    if (!in_bounds) begin
                        instruction_error <= 1'b1;
                        state             <= st_idle;
                    end else if (direct) begin
                        instruction_finished <= 1'b1;
                        state                <= st_idle;
                    end else begin
                        state <= st_rmw_read;
                    end
                end
                st_rmw_read:  state <= st_rmw_wait;     // RAM read in flight
                st_rmw_wait:  state <= st_rmw_write;
                st_rmw_write: begin
                    instruction_finished <= 1'b1;
                    state                <= st_idle;
                end
                st_clear: begin
                    if (clear_last) begin
                        instruction_finished <= 1'b1;
                        state                <= st_idle;
                    end
                end
                st_get_addr: begin
                    if (!in_bounds) begin
                        instruction_error <= 1'b1;
                        state             <= st_idle;
                    end else begin
                        state <= st_get_wait;
                    end
                end
                st_get_wait: state <= st_get_read;
                st_get_read: begin
                    instruction_finished <= 1'b1;
                    state                <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Argument latch, loaded on an accepted start
    always_ff @(posedge video_clk) begin
        if (accept) begin
            arg_x      <= {arg0, arg1};     // High byte first
            arg_y      <= {arg2, arg3};
            arg_value  <= (instruction == op_write_pixel_pos) ? arg4 : arg0;
            clear_fill <= arg0;
        end
    end

    // ========================================================================
    // Control strobes
    // ========================================================================
    always_comb begin
        cursor_load     = 1'b0;
        cursor_advance  = 1'b0;
        cursor_home     = 1'b0;
        clear_start     = 1'b0;
        clear_step      = 1'b0;
        rmw_capture     = 1'b0;
        extract_capture = 1'b0;
        ram_we          = 1'b0;
        ram_addr_sel    = 1'b0;
        data_sel        = 2'd0;
        case (state)
            st_idle:      clear_start = accept && (instruction == op_clear_screen);
            st_pixel_pos: cursor_load = 1'b1;
            st_write_pixel, st_write_pixel_pos: begin
                if (in_bounds && direct) begin
                    ram_we         = 1'b1;
                    cursor_load    = pos_cmd;   // Advance applies to the new position
                    cursor_advance = 1'b1;
                end
            end
            st_rmw_wait:  rmw_capture = 1'b1;   // Read data valid here
            st_rmw_write: begin
                ram_we         = 1'b1;
                data_sel       = 2'd1;
                cursor_load    = pos_cmd;
                cursor_advance = 1'b1;
            end
            st_clear: begin
                ram_we       = 1'b1;
                ram_addr_sel = 1'b1;
                data_sel     = 2'd2;
                clear_step   = 1'b1;
                cursor_home  = clear_last;
            end
            st_get_read:  extract_capture = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: design/gfx_top.sv
`timescale 1ns/100ps

module gfx_top #(
    parameter int addr_width = 17
) (
    input  logic       video_clk,
    input  logic       reset_n,
    input  logic [7:0] mode_control,
    input  logic [7:0] instruction,
    input  logic [7:0] arg0,
    input  logic [7:0] arg1,
    input  logic [7:0] arg2,
    input  logic [7:0] arg3,
    input  logic [7:0] arg4,
    input  logic       instruction_start,
    output logic       instruction_busy,
    output logic       instruction_finished,
    output logic       instruction_error,
    output logic [7:0] result_pixel
);
    import gfx_mode_pkg::*;

    mode_geom_t geom;
    coord_t     arg_x, arg_y, cursor_x, cursor_y;
    coord_t     pix_x, pix_y;
    vaddr_t     pixel_addr, clear_addr;
    logic [2:0] bit_pos;
    logic [7:0] arg_value, clear_fill, merged_byte;
    logic       in_bounds, clear_last;

    logic       cursor_load, cursor_advance, cursor_home;
    logic       clear_start, clear_step;
    logic       addr_sel, rmw_capture, extract_capture;
    logic       ram_we, ram_addr_sel;
    logic [1:0] data_sel;

    logic [addr_width-1:0] ram_addr;
    logic [7:0]            ram_wdata, ram_rdata;

    // ========================================================================
    // Datapath muxes
    // ========================================================================
    assign pix_x    = addr_sel ? arg_x : cursor_x;     // Argument or cursor position
    assign pix_y    = addr_sel ? arg_y : cursor_y;
    assign ram_addr = addr_width'(ram_addr_sel ? clear_addr : pixel_addr);

    always_comb begin
        case (data_sel)
            2'd1:    ram_wdata = merged_byte;   // Read-modify-write result
            2'd2:    ram_wdata = clear_fill;
            default: ram_wdata = arg_value;     // Direct 8 bpp write
        endcase
    end

    // ========================================================================
    // Blocks
    // ========================================================================
    gfx_cmd_fsm u_fsm (
        .video_clk, .reset_n, .instruction,
        .arg0, .arg1, .arg2, .arg3, .arg4, .instruction_start,
        .in_bounds, .clear_last, .geom,
        .instruction_busy, .instruction_finished, .instruction_error,
        .arg_x, .arg_y, .arg_value, .clear_fill,
        .cursor_load, .cursor_advance, .cursor_home,
        .clear_start, .clear_step, .addr_sel,
        .rmw_capture, .extract_capture,
        .ram_we, .ram_addr_sel, .data_sel
    );

    gfx_cursor u_cursor (
        .video_clk, .reset_n, .cursor_load,
        .load_x (arg_x),
        .load_y (arg_y),
        .cursor_advance, .cursor_home, .geom,
        .cursor_x, .cursor_y
    );

    gfx_clear_counter u_clear (
        .video_clk, .reset_n, .clear_start, .clear_step, .geom,
        .working_page (mode_control[4]),
        .clear_addr, .clear_last
    );

    gfx_pixel_addr u_addr (
        .mode_control,
        .x (pix_x),
        .y (pix_y),
        .geom, .pixel_addr, .bit_pos, .in_bounds
    );

    gfx_pixel_merge u_merge (
        .video_clk, .reset_n, .rmw_capture, .extract_capture,
        .ram_rdata, .bit_pos, .geom,
        .pixel_value (arg_value),
        .merged_byte, .result_pixel
    );

    video_ram #(.addr_width(addr_width)) u_ram (
        .video_clk,
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

// File: verif/gfx_sva.sv
`timescale 1ns/100ps

module gfx_sva (
    input logic video_clk,
    input logic reset_n,
    input logic instruction_busy,
    input logic instruction_finished,
    input logic instruction_error,
    input logic ram_we
);
    int unsigned n_excl  = 0;
    int unsigned n_pulse = 0;
    int unsigned n_idle  = 0;
    int unsigned n_we    = 0;
    int unsigned fail_count;

    assign fail_count = n_excl + n_pulse + n_idle + n_we;   // Read by the testbench

    // An instruction ends in finished or error, never both
    a_end_exclusive: assert property (@(posedge video_clk) disable iff (!reset_n)
        !(instruction_finished && instruction_error))
    else begin
        $error("finished and error high in the same cycle");
        n_excl = n_excl + 1;
    end

    a_one_cycle_pulse: assert property (@(posedge video_clk) disable iff (!reset_n)
        (instruction_finished || instruction_error) |=>
            !(instruction_finished || instruction_error))
    else begin
        $error("status pulse longer than one cycle");
        n_pulse = n_pulse + 1;
    end

    // Busy is gone one cycle after the end pulse
    a_busy_drops: assert property (@(posedge video_clk) disable iff (!reset_n)
        (instruction_finished || instruction_error) |=> !instruction_busy)
    else begin
        $error("busy still high after the end of an instruction");
        n_idle = n_idle + 1;
    end

    a_write_while_busy: assert property (@(posedge video_clk) disable iff (!reset_n)
        ram_we |-> instruction_busy)
    else begin
        $error("RAM write outside an instruction");
        n_we = n_we + 1;
    end

endmodule

// File: verif/tb_gfx.sv
`timescale 1ns/100ps

module tb_gfx;
    import gfx_cmd_pkg::*;

    localparam int done_limit = 100000;     // Longest clear is 76801 cycles
    localparam int idle_limit = 8;

    // One table row per instruction with the outcome it should produce
    typedef struct packed {
        logic [7:0]  mode;
        logic [7:0]  op;
        logic [15:0] x;
        logic [15:0] y;
        logic [7:0]  value;
        logic        expect_error;
        logic        check_result;
        logic [7:0]  expected;
    } step_t;

    logic       video_clk;
    logic       reset_n;
    logic [7:0] mode_control;
    logic [7:0] instruction;
    logic [7:0] arg0, arg1, arg2, arg3, arg4;
    logic       instruction_start;
    logic       instruction_busy;
    logic       instruction_finished;
    logic       instruction_error;
    logic [7:0] result_pixel;

    integer seed = 32'hd79a201b;
    step_t  steps[$];

    gfx_top #(.addr_width(17)) u_dut (.*);

    bind gfx_cmd_fsm gfx_sva u_sva (.*);

    initial begin
        video_clk = 1'b0;
        forever #50 video_clk = ~video_clk;
    end

    // ========================================================================
    // Reporting
    // ========================================================================
    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp_val);
        if (got !== exp_val) begin
            $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp_val);
            abort_run();
        end
    endtask

    // ========================================================================
    // Reference rules for the four modes
    // ========================================================================
    task automatic mode_info(input int m, output int w, output int h, output int bpp);
        case (m)
            2: begin
                w   = 640;
                h   = 480;
                bpp = 2;
            end
            3: begin
                w   = 320;
                h   = 240;
                bpp = 4;
            end
            4: begin
                w   = 320;
                h   = 240;
                bpp = 8;
            end
            default: begin
                w   = 640;
                h   = 480;
                bpp = 1;
            end
        endcase
    endtask

    function automatic logic [7:0] mask_of(input int bpp);
        return (bpp == 8) ? 8'hff : 8'((1 << bpp) - 1);
    endfunction

    // Pixel field of a byte with the leftmost pixel in the high bits
    function automatic logic [7:0] field_of(input logic [7:0] pix_byte, input int x,
                                            input int bpp);
        int shift;
        shift = 8 - bpp * (x % (8 / bpp) + 1);
        return (pix_byte >> shift) & mask_of(bpp);
    endfunction

    function automatic logic [7:0] mode_ctrl(input int m, input bit page);
        return {3'b000, page, 1'b0, 3'(m)};     // Page in bit 4 and mode in bits 2..0
    endfunction

    function automatic bit is_known(input logic [7:0] op);
        return (op >= 8'h10) && (op <= 8'h14);
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // ========================================================================
    // Table construction
    // ========================================================================
    task automatic add_step(input logic [7:0] mode, input logic [7:0] op, input int x,
                            input int y, input logic [7:0] value, input bit err,
                            input bit chk, input logic [7:0] exp_val);
        step_t s;
        s.mode         = mode;
        s.op           = op;
        s.x            = 16'(x);
        s.y            = 16'(y);
        s.value        = value;
        s.expect_error = err;
        s.check_result = chk;
        s.expected     = exp_val;
        steps.push_back(s);
    endtask

    task automatic build_unknown();
        logic [7:0] op;
        add_step(mode_ctrl(1, 1'b0), 8'h00, 0, 0, 8'd0, 1'b1, 1'b0, 8'd0);
        add_step(mode_ctrl(1, 1'b0), 8'h15, 0, 0, 8'd0, 1'b1, 1'b0, 8'd0);
        add_step(mode_ctrl(1, 1'b0), 8'hff, 0, 0, 8'd0, 1'b1, 1'b0, 8'd0);
        do
            op = 8'($random(seed));
        while (is_known(op));
        add_step(mode_ctrl(1, 1'b0), op, 0, 0, 8'd0, 1'b1, 1'b0, 8'd0);
    endtask

    task automatic build_mode(input int m);
        int         w, h, bpp, ppb, x, y, x0, y0, k;
        logic [7:0] mc, fill, a, b;
        logic [7:0] vals [8];
        mode_info(m, w, h, bpp);
        ppb  = 8 / bpp;
        mc   = mode_ctrl(m, 1'b0);
        fill = 8'($random(seed));
        add_step(mc, op_clear_screen, 0, 0, fill, 1'b0, 1'b0, 8'd0);
        for (k = 0; k < 3; k++) begin
            x = rand_below(w);
            y = rand_below(h);
            add_step(mc, op_get_pixel_at, x, y, 8'd0, 1'b0, 1'b1, field_of(fill, x, bpp));
        end
        a = 8'($random(seed));
        add_step(mc, op_write_pixel, 0, 0, a, 1'b0, 1'b0, 8'd0);   // Clear homed the cursor
        add_step(mc, op_get_pixel_at, 0, 0, 8'd0, 1'b0, 1'b1, a & mask_of(bpp));

        // Every pixel of one byte and then the whole byte again
        x0 = rand_below(w) / ppb * ppb;
        y0 = rand_below(h);
        for (k = 0; k < ppb; k++) begin
            vals[k] = 8'($random(seed));
            add_step(mc, op_write_pixel_pos, x0 + k, y0, vals[k], 1'b0, 1'b0, 8'd0);
            add_step(mc, op_get_pixel_at, x0 + k, y0, 8'd0, 1'b0, 1'b1,
                     vals[k] & mask_of(bpp));
        end
        for (k = 0; k < ppb; k++)
            add_step(mc, op_get_pixel_at, x0 + k, y0, 8'd0, 1'b0, 1'b1,
                     vals[k] & mask_of(bpp));

        // Cursor wrap at the end of a line
        y = rand_below(h - 1);
        a = 8'($random(seed));
        b = 8'($random(seed));
        add_step(mc, op_pixel_pos, w - 1, y, 8'd0, 1'b0, 1'b0, 8'd0);
        add_step(mc, op_write_pixel, 0, 0, a, 1'b0, 1'b0, 8'd0);
        add_step(mc, op_write_pixel, 0, 0, b, 1'b0, 1'b0, 8'd0);
        add_step(mc, op_get_pixel_at, w - 1, y, 8'd0, 1'b0, 1'b1, a & mask_of(bpp));
        add_step(mc, op_get_pixel_at, 0, y + 1, 8'd0, 1'b0, 1'b1, b & mask_of(bpp));

        // Coordinates past the edge of the mode
        add_step(mc, op_write_pixel_pos, w + rand_below(64), rand_below(h), 8'h5a,
                 1'b1, 1'b0, 8'd0);
        add_step(mc, op_write_pixel_pos, rand_below(w), h, 8'h3c, 1'b1, 1'b0, 8'd0);
        add_step(mc, op_get_pixel_at, rand_below(w), h + rand_below(64), 8'd0,
                 1'b1, 1'b0, 8'd0);
        add_step(mc, op_get_pixel_at, w, rand_below(h), 8'd0, 1'b1, 1'b0, 8'd0);
    endtask

    task automatic build_pages(input int m);
        int         w, h, bpp, x, y;
        logic [7:0] f0, f1, v;
        mode_info(m, w, h, bpp);
        f0 = 8'($random(seed));
        f1 = 8'($random(seed));
        v  = 8'($random(seed));
        x  = rand_below(w);
        y  = rand_below(h);
        add_step(mode_ctrl(m, 1'b0), op_clear_screen, 0, 0, f0, 1'b0, 1'b0, 8'd0);
        add_step(mode_ctrl(m, 1'b1), op_clear_screen, 0, 0, f1, 1'b0, 1'b0, 8'd0);
        add_step(mode_ctrl(m, 1'b1), op_write_pixel_pos, x, y, v, 1'b0, 1'b0, 8'd0);
        add_step(mode_ctrl(m, 1'b1), op_get_pixel_at, x, y, 8'd0, 1'b0, 1'b1,
                 v & mask_of(bpp));
        add_step(mode_ctrl(m, 1'b0), op_get_pixel_at, x, y, 8'd0, 1'b0, 1'b1,
                 field_of(f0, x, bpp));         // Page 0 untouched
        add_step(mode_ctrl(m, 1'b1), op_get_pixel_at, x, (y + 1) % h, 8'd0, 1'b0, 1'b1,
                 field_of(f1, x, bpp));
    endtask

    task automatic build_table();
        int m;
        build_unknown();
        for (m = 1; m <= 4; m++)
            build_mode(m);
        build_pages(1);
        build_pages(3);
    endtask

    // ========================================================================
    // One instruction on the DUT
    // ========================================================================
    task automatic run_step(input step_t s, output bit fin, output bit err,
                            output bit busy_seen);
        int n;
        fin       = 1'b0;
        err       = 1'b0;
        busy_seen = 1'b0;
        @(posedge video_clk);
        #5;
        mode_control = s.mode;
        instruction  = s.op;
        arg0 = (s.op == op_write_pixel || s.op == op_clear_screen) ? s.value : s.x[15:8];
        arg1 = s.x[7:0];
        arg2 = s.y[15:8];
        arg3 = s.y[7:0];
        arg4 = s.value;
        instruction_start = 1'b1;

        for (n = 0; n < done_limit && !fin && !err; n++) begin
            @(posedge video_clk);
            #1;
            busy_seen = busy_seen | instruction_busy;
            fin       = instruction_finished;
            err       = instruction_error;
        end
        if (!fin && !err) begin
            $display("Timeout: opcode %h gave neither finished nor error in %0d cycles",
                     s.op, done_limit);
            abort_run();
        end

        #4;
        instruction_start = 1'b0;
        for (n = 0; n < idle_limit && instruction_busy; n++) begin
            @(posedge video_clk);
            #1;
        end
        if (instruction_busy) begin
            $display("Timeout: busy still high %0d cycles after the instruction ended",
                     idle_limit);
            abort_run();
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        bit         fin, err, busy_seen;
        logic [7:0] held;                       // Last GET_PIXEL_AT value
        int         i;
        reset_n           = 1'b0;
        mode_control      = 8'h00;
        instruction       = 8'h00;
        arg0              = 8'h00;
        arg1              = 8'h00;
        arg2              = 8'h00;
        arg3              = 8'h00;
        arg4              = 8'h00;
        instruction_start = 1'b0;
        held              = 8'h00;
        build_table();

        repeat (10) @(posedge video_clk);
        #5;
        reset_n = 1'b1;
        check_value("busy after reset", 32'(instruction_busy), 32'd0);
        check_value("finished after reset", 32'(instruction_finished), 32'd0);
        check_value("error after reset", 32'(instruction_error), 32'd0);
        check_value("ram_we after reset", 32'(u_dut.ram_we), 32'd0);
        check_value("result_pixel after reset", 32'(result_pixel), 32'd0);

        for (i = 0; i < steps.size(); i++) begin
            run_step(steps[i], fin, err, busy_seen);
            check_value($sformatf("step %0d finished pulse", i), 32'(fin),
                        32'(!steps[i].expect_error));
            check_value($sformatf("step %0d error pulse", i), 32'(err),
                        32'(steps[i].expect_error));
            check_value($sformatf("step %0d busy raised", i), 32'(busy_seen),
                        32'(is_known(steps[i].op)));
            if (steps[i].check_result)
                held = steps[i].expected;
            check_value($sformatf("step %0d result_pixel", i),
                        32'(result_pixel), 32'(held));
            check_value($sformatf("step %0d assertion failures", i),
                        u_dut.u_fsm.u_sva.fail_count, 32'd0);
        end

        if (u_dut.u_fsm.u_sva.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", u_dut.u_fsm.u_sva.fail_count);
            abort_run();
        end
    end

endmodule

// File: all.f
design/gfx_mode_pkg.sv
design/gfx_cmd_pkg.sv
design/video_ram.sv
design/gfx_pixel_merge.sv
design/gfx_pixel_addr.sv
design/gfx_clear_counter.sv
design/gfx_cursor.sv
design/gfx_cmd_fsm.sv
design/gfx_top.sv
verif/gfx_sva.sv
verif/tb_gfx.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_gfx
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_FLAGS ?= +verilator+error+limit+100

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) $(SIM_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
